/* rtl/bus_params.svh */
`ifndef BUS_PARAMS_SVH
`define BUS_PARAMS_SVH

// bus widths seen by the outside master
`define BUS_ADDR_W 64
`define BUS_DATA_W 64

// ram window, byte address of word 0
`define RAM_BASE 64'h0000_0000_0000_1000

// depth in 32-bit words
`define RAM_WORDS 1024

// keyboard data register, read only
`define KEY_ADDR 64'h0000_0000_0000_8000

// console data register, write only
`define CON_ADDR 64'h0000_0000_0000_8008

`endif

/* rtl/bus_pkg.sv */
`default_nettype none
`include "bus_params.svh"

package bus_pkg;

    // word index width of the ram
    localparam int RAM_IDX_W = $clog2(`RAM_WORDS);

    // access size codes, shared by loads and stores
    localparam logic [1:0] SIZE_BYTE   = 2'd0;
    localparam logic [1:0] SIZE_HALF   = 2'd1;
    localparam logic [1:0] SIZE_WORD   = 2'd2;
    localparam logic [1:0] SIZE_DOUBLE = 2'd3;

    // load view: top bit selects zero extension
    typedef struct packed {
        logic       is_unsigned;
        logic [1:0] size;
    } load_kind_t;

    // store view: top bit carries nothing
    typedef struct packed {
        logic       rsvd;
        logic [1:0] size;
    } store_kind_t;

    // same three bits, decoded per direction
    typedef union packed {
        load_kind_t  ld;
        store_kind_t st;
    } access_kind_u;

    typedef struct packed {
        logic [`BUS_ADDR_W-1:0] addr;
        logic [`BUS_DATA_W-1:0] wdata;
        access_kind_u           kind;
    } bus_req_t;

    // one hot region select
    typedef struct packed {
        logic ram;
        logic key;
        logic con;
        logic unmapped;
    } region_sel_t;

    typedef struct packed {
        logic [RAM_IDX_W-1:0] idx;
        logic [3:0]           we;
        logic [31:0]          wdata;
        logic                 re;
    } ram_port_t;

endpackage

`default_nettype wire

/* rtl/addr_decoder.sv */
`timescale 1ns/100ps
`default_nettype none
`include "bus_params.svh"

module addr_decoder (
    input  wire logic [`BUS_ADDR_W-1:0] addr,
    output bus_pkg::region_sel_t        sel
);

    // size of the ram window in bytes
    localparam logic [`BUS_ADDR_W-1:0] RAM_BYTES = 64'(`RAM_WORDS) << 2;

    logic [`BUS_ADDR_W-1:0] ram_off;
    logic                   hit_ram;
    logic                   hit_key;
    logic                   hit_con;

    // offset into the window, wraps below the base
    assign ram_off = addr - `RAM_BASE;

    always_comb begin
        hit_ram = (addr >= `RAM_BASE) && (ram_off < RAM_BYTES);
        hit_key = (addr == `KEY_ADDR);
        hit_con = (addr == `CON_ADDR);
        sel.ram = hit_ram;
        sel.key = hit_key;
        sel.con = hit_con;
        // anything else completes with no effect
        sel.unmapped = !(hit_ram || hit_key || hit_con);
    end

endmodule

`default_nettype wire

/* rtl/ram_bank.sv */
`timescale 1ns/100ps
`default_nettype none
`include "bus_params.svh"

module ram_bank (
    input  wire logic                CLOCK_50,
    input  wire bus_pkg::ram_port_t  port,
    output logic [31:0]              rdata
);

    // word wide storage, byte lanes written separately
    logic [31:0] mem [0:`RAM_WORDS-1];

    always_ff @(posedge CLOCK_50) begin
        // lane 0 is bits 7..0
        for (int lane = 0; lane < 4; lane++) begin
            if (port.we[lane]) begin
                mem[port.idx][lane*8 +: 8] <= port.wdata[lane*8 +: 8];
            end
        end
        // read word held until the next strobe
        if (port.re) begin
            rdata <= mem[port.idx];
        end
    end

    // the sequencer never mixes a read beat with a write beat
    a_no_rw_collision: assert property (
        @(posedge CLOCK_50) !(port.re && (|port.we))
    ) else $error("ram read strobe and write enables active together");

endmodule

`default_nettype wire

/* rtl/load_aligner.sv */
`timescale 1ns/100ps
`default_nettype none

module load_aligner (
    input  wire logic [31:0]         raw_lo,
    input  wire logic [31:0]         raw_hi,
    input  wire logic [1:0]          offset,
    input  wire bus_pkg::load_kind_t kind,
    output logic [63:0]              value
);

    logic [31:0] lane_data;
    logic        sign_b;
    logic        sign_h;
    logic        sign_w;

    // move the addressed lane down to bit 0
    assign lane_data = raw_lo >> {offset, 3'b000};

    // fill bits, forced to zero for unsigned loads
    assign sign_b = lane_data[7] & ~kind.is_unsigned;
    assign sign_h = lane_data[15] & ~kind.is_unsigned;
    assign sign_w = raw_lo[31] & ~kind.is_unsigned;

    always_comb begin
        case (kind.size)
            bus_pkg::SIZE_BYTE: value = {{56{sign_b}}, lane_data[7:0]};
            bus_pkg::SIZE_HALF: value = {{48{sign_h}}, lane_data[15:0]};
            bus_pkg::SIZE_WORD: value = {{32{sign_w}}, raw_lo};
            // double, low half first in memory
            default: value = {raw_hi, raw_lo};
        endcase
    end

endmodule

`default_nettype wire

/* rtl/bus_sequencer.sv */
`timescale 1ns/100ps
`default_nettype none
`include "bus_params.svh"

module bus_sequencer (
    input  wire logic                 CLOCK_50,
    input  wire logic                 KEY0,
    input  wire logic                 rd_en,
    input  wire logic                 wr_en,
    input  wire bus_pkg::bus_req_t    req,
    input  wire bus_pkg::region_sel_t sel,
    input  wire logic [7:0]           key_code,
    input  wire logic [31:0]          ram_rdata,
    output bus_pkg::ram_port_t        ram,
    output logic                      done,
    output logic [`BUS_DATA_W-1:0]    rd_data,
    output logic                      con_strobe,
    output logic [7:0]                con_data
);

    localparam logic [1:0] ST_IDLE   = 2'd0;
    localparam logic [1:0] ST_BEAT1  = 2'd1;
    localparam logic [1:0] ST_BEAT2  = 2'd2;
    localparam logic [1:0] ST_FINISH = 2'd3;

    logic [1:0]                    state;
    logic                          is_wr;
    logic                          is_double;
    logic [1:0]                    offset;
    logic [`BUS_ADDR_W-1:0]        ram_off;
    logic [bus_pkg::RAM_IDX_W-1:0] word_idx;
    logic [3:0]                    lane_we;
    logic [31:0]                   lane_wdata;
    logic [31:0]                   lo_word;
    logic [63:0]                   aligned;
    logic                          aligned_ok;

    assign offset    = req.addr[1:0];
    assign is_double = (req.kind.st.size == bus_pkg::SIZE_DOUBLE);
    assign ram_off   = req.addr - `RAM_BASE;
    assign word_idx  = ram_off[bus_pkg::RAM_IDX_W+1:2];

    // store lanes from the store view of the kind field
    always_comb begin
        case (req.kind.st.size)
            bus_pkg::SIZE_BYTE: lane_we = 4'b0001 << offset;
            bus_pkg::SIZE_HALF: lane_we = 4'b0011 << offset;
            default:            lane_we = 4'b1111;
        endcase
    end

    // data moved up into its lane, the enables mask the rest
    assign lane_wdata = req.wdata[31:0] << {offset, 3'b000};

    // ram port is live only during the beat states
    always_comb begin
        ram = '0;
        if (sel.ram && (state == ST_BEAT1 || state == ST_BEAT2)) begin
            // second beat goes to the next word
            ram.idx = (state == ST_BEAT2) ? word_idx + 1'b1 : word_idx;
            ram.re  = !is_wr;
            if (is_wr) begin
                if (state == ST_BEAT2) begin
                    ram.we    = 4'b1111;
                    ram.wdata = req.wdata[63:32];
                end else begin
                    ram.we    = lane_we;
                    ram.wdata = lane_wdata;
                end
            end
        end
    end

    // a double keeps its low word, a single beat reads straight through
    load_aligner u_load_aligner (
        .raw_lo (is_double ? lo_word : ram_rdata),
        .raw_hi (ram_rdata),
        .offset (offset),
        .kind   (req.kind.ld),
        .value  (aligned)
    );

    always_ff @(posedge CLOCK_50 or negedge KEY0) begin
        if (!KEY0) begin
            state      <= ST_IDLE;
            done       <= 1'b1;
            is_wr      <= 1'b0;
            rd_data    <= '0;
            con_strobe <= 1'b0;
        end else begin
            con_strobe <= 1'b0;
            case (state)
                ST_IDLE: begin
                    if (rd_en || wr_en) begin
                        done  <= 1'b0;
                        is_wr <= wr_en;
                        state <= ST_BEAT1;
                        // strobe lands while done is still low
                        con_strobe <= wr_en && sel.con;
                    end
                end
                ST_BEAT1: begin
                    if (sel.ram) begin
                        if (is_double) begin
                            state <= ST_BEAT2;
                        end else if (is_wr) begin
                            done  <= 1'b1;
                            state <= ST_IDLE;
                        end else begin
                            state <= ST_FINISH;
                        end
                    end else begin
                        // registers and unmapped finish here
                        if (!is_wr) begin
                            rd_data <= sel.key ? {56'd0, key_code} : '0;
                        end
                        done  <= 1'b1;
                        state <= ST_IDLE;
                    end
                end
                ST_BEAT2: begin
                    if (is_wr) begin
                        done  <= 1'b1;
                        state <= ST_IDLE;
                    end else begin
                        state <= ST_FINISH;
                    end
                end
                default: begin
                    // ram word is back, extended value goes out
                    rd_data <= aligned;
                    done    <= 1'b1;
                    state   <= ST_IDLE;
                end
            endcase
        end
    end

    always_ff @(posedge CLOCK_50) begin
        if (state == ST_IDLE && wr_en && sel.con) begin
            con_data <= req.wdata[7:0];
        end
        // first beat of a double load
        if (state == ST_BEAT2 && !is_wr) begin
            lo_word <= ram_rdata;
        end
    end

    // natural alignment per size
    always_comb begin
        case (req.kind.st.size)
            bus_pkg::SIZE_BYTE: aligned_ok = 1'b1;
            bus_pkg::SIZE_HALF: aligned_ok = !req.addr[0];
            default:            aligned_ok = (req.addr[1:0] == 2'b00);
        endcase
    end

    a_no_enable_busy: assert property (
        @(posedge CLOCK_50) disable iff (!KEY0)
        (rd_en || wr_en) |-> done
    ) else $error("bus enable while an access is outstanding");

    a_ram_aligned: assert property (
        @(posedge CLOCK_50) disable iff (!KEY0)
        ((rd_en || wr_en) && sel.ram) |-> aligned_ok
    ) else $error("misaligned ram access");

endmodule

`default_nettype wire

/* rtl/key_irq.sv */
`timescale 1ns/100ps
`default_nettype none

module key_irq (
    input  wire logic CLOCK_50,
    input  wire logic KEY0,
    input  wire logic key_valid,
    input  wire logic [7:0] key_ascii,
    input  wire logic irq_ack,
    output logic [7:0] key_code,
    output logic [3:0] irq_vector,
    output logic irq_led
);

    logic key_hit;

    // zero codes are ignored entirely
    assign key_hit = key_valid && (key_ascii != 8'd0);

    always_ff @(posedge CLOCK_50 or negedge KEY0) begin
        if (!KEY0) begin
            key_code   <= 8'd0;
            irq_vector <= 4'd0;
            irq_led    <= 1'b0;
        end else begin
            if (key_hit) begin
                key_code   <= key_ascii;
                irq_vector <= 4'd1;
                irq_led    <= 1'b1;
            end
            // ack wins over a press in the same cycle
            if (irq_ack && irq_vector != 4'd0) begin
                irq_vector <= 4'd0;
                irq_led    <= 1'b0;
            end
        end
    end

endmodule

`default_nettype wire

/* rtl/bus_fabric_top.sv */
`timescale 1ns/100ps
`default_nettype none
`include "bus_params.svh"

module bus_fabric_top (
    input  wire logic                  CLOCK_50,
    input  wire logic                  KEY0,
    input  wire logic                  rd_en,
    input  wire logic                  wr_en,
    input  wire bus_pkg::bus_req_t     bus_req,
    output logic                       done,
    output logic [`BUS_DATA_W-1:0]     rd_data,
    input  wire logic                  key_valid,
    input  wire logic [7:0]            key_ascii,
    input  wire logic                  irq_ack,
    output logic [3:0]                 irq_vector,
    output logic                       irq_led,
    output logic                       con_strobe,
    output logic [7:0]                 con_data
);

    bus_pkg::region_sel_t sel;
    bus_pkg::ram_port_t   ram_port;
    logic [31:0]          ram_rdata;
    logic [7:0]           key_code;

    // region select from the held address
    addr_decoder u_addr_decoder (
        .addr (bus_req.addr),
        .sel  (sel)
    );

    bus_sequencer u_bus_sequencer (
        .CLOCK_50   (CLOCK_50),
        .KEY0       (KEY0),
        .rd_en      (rd_en),
        .wr_en      (wr_en),
        .req        (bus_req),
        .sel        (sel),
        .key_code   (key_code),
        .ram_rdata  (ram_rdata),
        .ram        (ram_port),
        .done       (done),
        .rd_data    (rd_data),
        .con_strobe (con_strobe),
        .con_data   (con_data)
    );

    ram_bank u_ram_bank (
        .CLOCK_50 (CLOCK_50),
        .port     (ram_port),
        .rdata    (ram_rdata)
    );

    // keyboard latch and interrupt
    key_irq u_key_irq (
        .CLOCK_50   (CLOCK_50),
        .KEY0       (KEY0),
        .key_valid  (key_valid),
        .key_ascii  (key_ascii),
        .irq_ack    (irq_ack),
        .key_code   (key_code),
        .irq_vector (irq_vector),
        .irq_led    (irq_led)
    );

endmodule

`default_nettype wire

/* verification/tb_tasks.svh */
`ifndef TB_TASKS_SVH
`define TB_TASKS_SVH

task automatic abort_run();
    $display("TEST FAILED");
    $fatal(1, "stopping at the first error");
endtask

task automatic check_value(input string name, input logic [63:0] actual,
                           input logic [63:0] expected);
    if (actual !== expected) begin
        $display("Fail %s: got 0x%h, expected 0x%h", name, actual, expected);
        abort_run();
    end
endtask

// unsigned flag above the size code
function automatic logic [2:0] kind_of(input logic uns, input logic [1:0] size);
    return {uns, size};
endfunction

task automatic next_rand(output logic [63:0] value);
    logic [31:0] hi;
    logic [31:0] lo;
    hi = $random(seed);
    lo = $random(seed);
    value = {hi, lo};
endtask

// aligned word, never the last one so a double still fits
task automatic rand_word_addr(output logic [63:0] addr);
    logic [31:0] r;
    r = $random(seed);
    addr = `RAM_BASE + {52'd0, r[9:0] % 10'd1023, 2'b00};
endtask

// one enable cycle, then wait for done and count console strobes
task automatic bus_access(input logic write, input logic [63:0] addr,
                          input logic [63:0] wdata, input logic [2:0] kind,
                          output logic [63:0] rdata, output int strobes,
                          output logic [7:0] strobe_data);
    int cycles;
    strobes     = 0;
    strobe_data = 8'd0;
    cycles      = 0;
    @(posedge CLOCK_50);
    bus_req.addr  <= addr;
    bus_req.wdata <= wdata;
    bus_req.kind  <= kind;
    rd_en         <= !write;
    wr_en         <= write;
    @(posedge CLOCK_50);
    rd_en <= 1'b0;
    wr_en <= 1'b0;
    @(negedge CLOCK_50);
    // done falls on the edge that takes the enable
    check_value("done", 64'(done), 64'd0);
    while (!done) begin
        if (con_strobe) begin
            strobes++;
            strobe_data = con_data;
        end
        cycles++;
        if (cycles > DONE_TIMEOUT) begin
            $display("timeout: done did not rise for the access at 0x%h", addr);
            abort_run();
        end
        @(negedge CLOCK_50);
    end
    // the pulse belongs before done rises
    if (con_strobe) begin
        $display("con_strobe was still high when done rose for the access at 0x%h", addr);
        abort_run();
    end
    rdata = rd_data;
endtask

task automatic ram_store(input logic [63:0] addr, input logic [1:0] size,
                         input logic [63:0] wdata);
    logic [63:0] rdata;
    int          strobes;
    logic [7:0]  sdata;
    bus_access(1'b1, addr, wdata, kind_of(1'b0, size), rdata, strobes, sdata);
    model_store(addr, size, wdata);
    check_value("con_strobe count", 64'(strobes), 64'd0);
endtask

task automatic ram_load_check(input logic [63:0] addr, input logic [1:0] size,
                              input logic uns, output logic [63:0] value);
    int          strobes;
    logic [7:0]  sdata;
    bus_access(1'b0, addr, 64'd0, kind_of(uns, size), value, strobes, sdata);
    check_value("rd_data", value, model_load(addr, size, uns));
endtask

task automatic read_key(output logic [63:0] value);
    int         strobes;
    logic [7:0] sdata;
    bus_access(1'b0, `KEY_ADDR, 64'd0, kind_of(1'b0, bus_pkg::SIZE_BYTE), value,
               strobes, sdata);
endtask

// latch and interrupt settle on the second edge
task automatic key_pulse(input logic [7:0] code);
    @(posedge CLOCK_50);
    key_valid <= 1'b1;
    key_ascii <= code;
    @(posedge CLOCK_50);
    key_valid <= 1'b0;
    key_ascii <= 8'd0;
    @(negedge CLOCK_50);
endtask

task automatic ack_pulse();
    @(posedge CLOCK_50);
    irq_ack <= 1'b1;
    @(posedge CLOCK_50);
    irq_ack <= 1'b0;
    @(negedge CLOCK_50);
endtask

task automatic check_irq(input logic [3:0] vector, input logic led);
    check_value("irq_vector", 64'(irq_vector), 64'(vector));
    check_value("irq_led", 64'(irq_led), 64'(led));
endtask

task automatic test_reset_state();
    @(negedge CLOCK_50);
    check_value("done", 64'(done), 64'd1);
    check_value("rd_data", rd_data, 64'd0);
    check_value("con_strobe", 64'(con_strobe), 64'd0);
    check_irq(4'd0, 1'b0);
endtask

task automatic test_word_double();
    logic [63:0] addr;
    logic [63:0] data;
    logic [63:0] value;
    int          n;
    for (n = 0; n < 8; n++) begin
        rand_word_addr(addr);
        next_rand(data);
        ram_store(addr, bus_pkg::SIZE_WORD, data);
        ram_load_check(addr, bus_pkg::SIZE_WORD, 1'b0, value);
        ram_load_check(addr, bus_pkg::SIZE_WORD, 1'b1, value);
    end
    for (n = 0; n < 4; n++) begin
        rand_word_addr(addr);
        next_rand(data);
        ram_store(addr, bus_pkg::SIZE_DOUBLE, data);
        ram_load_check(addr, bus_pkg::SIZE_DOUBLE, 1'b0, value);
        check_value("double readback", value, data);
        // the two halves one word apart
        ram_load_check(addr, bus_pkg::SIZE_WORD, 1'b1, value);
        ram_load_check(addr + 64'd4, bus_pkg::SIZE_WORD, 1'b1, value);
    end
endtask

task automatic test_byte_half();
    logic [63:0] addr;
    logic [63:0] data;
    logic [63:0] value;
    int          off;
    int          round;
    for (round = 0; round < 2; round++) begin
        rand_word_addr(addr);
        next_rand(data);
        ram_store(addr, bus_pkg::SIZE_WORD, data);
        for (off = 0; off < 4; off++) begin
            next_rand(data);
            // even lanes negative, odd lanes positive
            data[7] = (off % 2 == 0);
            ram_store(addr + 64'(off), bus_pkg::SIZE_BYTE, data);
        end
        for (off = 0; off < 4; off++) begin
            ram_load_check(addr + 64'(off), bus_pkg::SIZE_BYTE, 1'b0, value);
            ram_load_check(addr + 64'(off), bus_pkg::SIZE_BYTE, 1'b1, value);
        end
        for (off = 0; off < 4; off += 2) begin
            next_rand(data);
            data[15] = (off == 0);
            ram_store(addr + 64'(off), bus_pkg::SIZE_HALF, data);
        end
        for (off = 0; off < 4; off += 2) begin
            ram_load_check(addr + 64'(off), bus_pkg::SIZE_HALF, 1'b0, value);
            ram_load_check(addr + 64'(off), bus_pkg::SIZE_HALF, 1'b1, value);
        end
        ram_load_check(addr, bus_pkg::SIZE_WORD, 1'b0, value);
    end
endtask

task automatic test_console();
    logic [63:0] data;
    logic [63:0] value;
    int          strobes;
    logic [7:0]  sdata;
    int          n;
    for (n = 0; n < 3; n++) begin
        next_rand(data);
        bus_access(1'b1, `CON_ADDR, data, kind_of(1'b0, bus_pkg::SIZE_BYTE), value,
                   strobes, sdata);
        check_value("con_strobe count", 64'(strobes), 64'd1);
        check_value("con_data", 64'(sdata), 64'(data[7:0]));
    end
    // no stray pulse once idle
    for (n = 0; n < 3; n++) begin
        @(negedge CLOCK_50);
        check_value("con_strobe", 64'(con_strobe), 64'd0);
    end
endtask

task automatic test_key_irq();
    logic [31:0] r;
    logic [7:0]  code;
    logic [7:0]  code2;
    logic [63:0] value;
    r = $random(seed);
    // printable ascii, never zero
    code  = (r[7:0] % 8'd94) + 8'd33;
    code2 = (r[15:8] % 8'd94) + 8'd33;
    // second code must differ to show the latch moved
    if (code2 == code) begin
        code2 = code + 8'd1;
    end
    // latch still empty from reset
    read_key(value);
    check_value("rd_data", value, 64'd0);
    key_pulse(code);
    check_irq(4'd1, 1'b1);
    read_key(value);
    check_value("rd_data", value, {56'd0, code});
    // reading the code leaves the request pending
    check_irq(4'd1, 1'b1);
    ack_pulse();
    check_irq(4'd0, 1'b0);
    key_pulse(8'd0);
    check_irq(4'd0, 1'b0);
    read_key(value);
    check_value("rd_data", value, {56'd0, code});
    // zero code while a request is pending
    key_pulse(code2);
    key_pulse(8'd0);
    check_irq(4'd1, 1'b1);
    read_key(value);
    check_value("rd_data", value, {56'd0, code2});
    ack_pulse();
    check_irq(4'd0, 1'b0);
endtask

task automatic test_unmapped();
    logic [63:0] holes [0:2];
    logic [63:0] last;
    logic [63:0] data;
    logic [63:0] value;
    int          strobes;
    logic [7:0]  sdata;
    int          n;
    // just below the window, just past it, and a gap
    holes[0] = `RAM_BASE - 64'd4;
    holes[1] = `RAM_BASE + 64'(`RAM_WORDS * 4);
    holes[2] = 64'h0000_0000_0000_4000;
    last = `RAM_BASE + 64'((`RAM_WORDS - 1) * 4);
    next_rand(data);
    ram_store(`RAM_BASE, bus_pkg::SIZE_WORD, data);
    next_rand(data);
    ram_store(last, bus_pkg::SIZE_WORD, data);
    for (n = 0; n < 3; n++) begin
        // leave rd_data holding ram data first
        ram_load_check(`RAM_BASE, bus_pkg::SIZE_WORD, 1'b1, value);
        bus_access(1'b0, holes[n], 64'd0, kind_of(1'b1, bus_pkg::SIZE_WORD), value,
                   strobes, sdata);
        check_value("rd_data", value, 64'd0);
        next_rand(data);
        bus_access(1'b1, holes[n], data, kind_of(1'b0, bus_pkg::SIZE_WORD), value,
                   strobes, sdata);
        check_value("con_strobe count", 64'(strobes), 64'd0);
    end
    // wrapped word index would land on these two
    ram_load_check(`RAM_BASE, bus_pkg::SIZE_WORD, 1'b1, value);
    ram_load_check(last, bus_pkg::SIZE_WORD, 1'b1, value);
endtask

`endif

/* verification/tb_bus_fabric.sv */
`timescale 1ns/100ps
`default_nettype none
`include "bus_params.svh"

module tb_bus_fabric;

    // longest access is four cycles, the rest is slack
    localparam int DONE_TIMEOUT = 20;

    logic                CLOCK_50;
    logic                KEY0;
    logic                rd_en;
    logic                wr_en;
    bus_pkg::bus_req_t   bus_req;
    logic                done;
    logic [63:0]         rd_data;
    logic                key_valid;
    logic [7:0]          key_ascii;
    logic                irq_ack;
    logic [3:0]          irq_vector;
    logic                irq_led;
    logic                con_strobe;
    logic [7:0]          con_data;

    // byte image of the ram window, lowest address first
    logic [7:0] model_mem [0:`RAM_WORDS*4-1];
    integer     seed;

    bus_fabric_top u_bus_fabric_top (
        .CLOCK_50   (CLOCK_50),
        .KEY0       (KEY0),
        .rd_en      (rd_en),
        .wr_en      (wr_en),
        .bus_req    (bus_req),
        .done       (done),
        .rd_data    (rd_data),
        .key_valid  (key_valid),
        .key_ascii  (key_ascii),
        .irq_ack    (irq_ack),
        .irq_vector (irq_vector),
        .irq_led    (irq_led),
        .con_strobe (con_strobe),
        .con_data   (con_data)
    );

    // 100 MHz
    initial begin
        CLOCK_50 = 1'b0;
        forever #5 CLOCK_50 = ~CLOCK_50;
    end

    // little endian, lane 0 at the access address
    task automatic model_store(input logic [63:0] addr, input logic [1:0] size,
                               input logic [63:0] wdata);
        int base;
        int nbytes;
        int i;
        base   = int'(addr - `RAM_BASE);
        nbytes = 1 << size;
        for (i = 0; i < nbytes; i++) begin
            model_mem[base + i] = wdata[i*8 +: 8];
        end
    endtask

    // gather the bytes, then fill above the top one
    function automatic logic [63:0] model_load(input logic [63:0] addr,
                                               input logic [1:0] size, input logic uns);
        int          base;
        int          nbytes;
        int          i;
        logic [63:0] val;
        logic        fill;
        base   = int'(addr - `RAM_BASE);
        nbytes = 1 << size;
        val    = '0;
        for (i = 0; i < nbytes; i++) begin
            val[i*8 +: 8] = model_mem[base + i];
        end
        // zero fill for unsigned loads
        fill = !uns && val[nbytes*8-1];
        for (i = nbytes * 8; i < 64; i++) begin
            val[i] = fill;
        end
        return val;
    endfunction

    `include "tb_tasks.svh"

    initial begin
        seed = 62;
        KEY0      <= 1'b0;
        rd_en     <= 1'b0;
        wr_en     <= 1'b0;
        bus_req   <= '0;
        key_valid <= 1'b0;
        key_ascii <= 8'd0;
        irq_ack   <= 1'b0;
        // hold reset for five edges
        repeat (5) @(posedge CLOCK_50);
        KEY0 <= 1'b1;
        test_reset_state();
        test_word_double();
        test_byte_half();
        test_console();
        test_key_irq();
        test_unmapped();
        $display("TEST PASSED");
        $finish;
    end

endmodule

`default_nettype wire

/* all.f */
+incdir+rtl
+incdir+verification
rtl/bus_pkg.sv
rtl/addr_decoder.sv
rtl/ram_bank.sv
rtl/load_aligner.sv
rtl/bus_sequencer.sv
rtl/key_irq.sv
rtl/bus_fabric_top.sv
verification/tb_bus_fabric.sv

/* run_sim.sh */
#!/bin/sh
# build and run the bus fabric testbench with verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -f all.f --top-module tb_bus_fabric -Mdir obj_dir
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/Vtb_bus_fabric > "$LOG" 2>&1
status=$?
cat "$LOG"

# verdict comes from the log
if grep -q "TEST FAILED" "$LOG"; then
    echo "simulation reported a failure"
    exit 1
fi
if [ $status -ne 0 ]; then
    echo "simulator exited with status $status"
    exit 1
fi
if ! grep -q "TEST PASSED" "$LOG"; then
    echo "simulation ended without a verdict"
    exit 1
fi
exit 0
